// ==== Makefile ====
# Verilator flow for the single-cycle core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module cpu_top -f verilog.f
	verilator --lint-only --timing --assert --top-module tb_cpu -f verilog.f

sim:
	verilator --binary --timing --assert --top-module tb_cpu -f verilog.f -o sim_cpu
	./obj_dir/sim_cpu | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cpu_top.sv ====
module cpu_top #(
	parameter rv_pkg::xlen_t RESET_PC = '0
) (
	input  logic          clk,
	input  logic          rst,
	input  rv_pkg::xlen_t imem_data,
	input  rv_pkg::xlen_t dmem_rdata,
	output rv_pkg::xlen_t imem_addr,
	output rv_pkg::xlen_t dmem_addr,
	output rv_pkg::xlen_t dmem_wdata,
	output logic [7:0]    dmem_wmask,
	output logic          dmem_wen,
	output logic          dmem_ren
);

	logic [6:0]    opcode;
	logic [2:0]    funct3;
	logic [6:0]    funct7;
	logic [4:0]    rs1;
	logic [4:0]    rs2;
	logic [4:0]    rd;
	rv_pkg::xlen_t imm;
	rv_pkg::xlen_t src1;
	rv_pkg::xlen_t src2;
	rv_pkg::xlen_t val;
	logic          rd_wen;
	rv_pkg::xlen_t jump;
	logic          jump_en;

	pc_reg #(
		.RESET_PC(RESET_PC)
	) u_pc_reg (
		.clk     (clk),
		.rst     (rst),
		.jump    (jump),
		.jump_en (jump_en),
		.pc      (imem_addr) // fetch address is the pc
	);

	idu u_idu (
		.instr  (imem_data),
		.opcode (opcode),
		.funct3 (funct3),
		.funct7 (funct7),
		.rs1    (rs1),
		.rs2    (rs2),
		.rd     (rd),
		.imm    (imm)
	);

	regfile u_regfile (
		.clk    (clk),
		.rst    (rst),
		.rs1    (rs1),
		.rs2    (rs2),
		.rd     (rd),
		.rd_wen (rd_wen),
		.wdata  (val),
		.src1   (src1),
		.src2   (src2)
	);

	exu u_exu (
		.rst        (rst),
		.opcode     (opcode),
		.funct3     (funct3),
		.funct7     (funct7),
		.src1       (src1),
		.src2       (src2),
		.imm        (imm),
		.pc         (imem_addr),
		.dmem_rdata (dmem_rdata),
		.val        (val),
		.rd_wen     (rd_wen),
		.jump       (jump),
		.jump_en    (jump_en),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wmask (dmem_wmask),
		.dmem_wen   (dmem_wen),
		.dmem_ren   (dmem_ren)
	);

endmodule

// ==== exu.sv ====
module exu (
	input  logic          rst,
	input  logic [6:0]    opcode,
	input  logic [2:0]    funct3,
	input  logic [6:0]    funct7,
	input  rv_pkg::xlen_t src1,
	input  rv_pkg::xlen_t src2,
	input  rv_pkg::xlen_t imm,
	input  rv_pkg::xlen_t pc,
	input  rv_pkg::xlen_t dmem_rdata,
	output rv_pkg::xlen_t val,
	output logic          rd_wen,
	output rv_pkg::xlen_t jump,
	output logic          jump_en,
	output rv_pkg::xlen_t dmem_addr,
	output rv_pkg::xlen_t dmem_wdata,
	output logic [7:0]    dmem_wmask,
	output logic          dmem_wen,
	output logic          dmem_ren
);

	logic val_vld;
	logic st_vld;

	rv_pkg::xlen_t pc_link;

	assign pc_link = pc + 32'd4;

	// writeback value and jump target
	always_comb begin
		val     = '0;
		val_vld = 1'b0;
		jump    = '0;
		jump_en = 1'b0;
		case (opcode)
			rv_pkg::OP_LUI: begin
				val     = imm;
				val_vld = 1'b1;
			end
			rv_pkg::OP_AUIPC: begin
				val     = pc + imm;
				val_vld = 1'b1;
			end
			rv_pkg::OP_JAL: begin
				val     = pc_link;
				val_vld = 1'b1;
				jump    = pc + imm;
				jump_en = 1'b1;
			end
			rv_pkg::OP_JALR: begin
				if (funct3 == 3'd0) begin
					val     = pc_link;
					val_vld = 1'b1;
					jump    = (src1 + imm) & ~32'd1;
					jump_en = 1'b1;
				end
			end
			rv_pkg::OP_LOAD: begin
				if (funct3 == 3'd2) begin // lw only
					val     = dmem_rdata;
					val_vld = 1'b1;
				end
			end
			rv_pkg::OP_IMM: begin
				if (funct3 == 3'd0) begin // addi
					val     = src1 + imm;
					val_vld = 1'b1;
				end
			end
			rv_pkg::OP_REG: begin
				if ((funct7 == 7'd0) && (funct3 == 3'd0)) begin // add
					val     = src1 + src2;
					val_vld = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	// store byte mask, unshifted
	always_comb begin
		dmem_wmask = 8'h0;
		if (opcode == rv_pkg::OP_STORE) begin
			case (funct3)
				3'd0: dmem_wmask = 8'h1;
				3'd1: dmem_wmask = 8'h3;
				3'd2: dmem_wmask = 8'hf;
				default: dmem_wmask = 8'h0;
			endcase
		end
	end

	assign st_vld = (dmem_wmask != 8'h0);

	assign dmem_addr  = src1 + imm;
	assign dmem_wdata = src2;
	assign dmem_ren   = (opcode == rv_pkg::OP_LOAD) || (opcode == rv_pkg::OP_STORE);
	assign dmem_wen   = st_vld && !rst;
	assign rd_wen     = val_vld && !rst;

endmodule

// ==== idu.sv ====
module idu (
	input  rv_pkg::xlen_t instr,
	output logic [6:0]    opcode,
	output logic [2:0]    funct3,
	output logic [6:0]    funct7,
	output logic [4:0]    rs1,
	output logic [4:0]    rs2,
	output logic [4:0]    rd,
	output rv_pkg::xlen_t imm
);

	rv_pkg::instr_t ir;

	rv_pkg::xlen_t imm_i;
	rv_pkg::xlen_t imm_s;
	rv_pkg::xlen_t imm_u;
	rv_pkg::xlen_t imm_j;

	assign ir = rv_pkg::instr_t'(instr);

	// register and function fields sit at the same place in every format
	assign opcode = ir.r.opcode;
	assign funct3 = ir.r.funct3;
	assign funct7 = ir.r.funct7;
	assign rs1    = ir.r.rs1;
	assign rs2    = ir.r.rs2;
	assign rd     = ir.r.rd;

	assign imm_i = {{20{ir.i.imm12[11]}}, ir.i.imm12};
	assign imm_s = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
	assign imm_u = {ir.u.imm20, 12'b0};
	assign imm_j = {
		{12{ir.j.imm20}},
		ir.j.imm19_12,
		ir.j.imm11,
		ir.j.imm10_1,
		1'b0
	};

	always_comb begin
		case (ir.r.opcode)
			rv_pkg::OP_JALR,
			rv_pkg::OP_LOAD,
			rv_pkg::OP_IMM: begin
				imm = imm_i;
			end
			rv_pkg::OP_STORE: begin
				imm = imm_s;
			end
			rv_pkg::OP_LUI,
			rv_pkg::OP_AUIPC: begin
				imm = imm_u;
			end
			rv_pkg::OP_JAL: begin
				imm = imm_j;
			end
			default: begin
				imm = '0; // r-type and unknown
			end
		endcase
	end

endmodule

// ==== pc_reg.sv ====
module pc_reg #(
	parameter rv_pkg::xlen_t RESET_PC = '0
) (
	input  logic          clk,
	input  logic          rst,
	input  rv_pkg::xlen_t jump,
	input  logic          jump_en,
	output rv_pkg::xlen_t pc
);

	rv_pkg::xlen_t pc_next;
	rv_pkg::xlen_t pc_seq;

	assign pc_seq = pc + 32'd4;

	// jal/jalr override the sequential step
	always_comb begin
		if (jump_en) begin
			pc_next = jump;
		end else begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// ==== regfile.sv ====
module regfile (
	input  logic          clk,
	input  logic          rst,
	input  logic [4:0]    rs1,
	input  logic [4:0]    rs2,
	input  logic [4:0]    rd,
	input  logic          rd_wen,
	input  rv_pkg::xlen_t wdata,
	output rv_pkg::xlen_t src1,
	output rv_pkg::xlen_t src2
);

	rv_pkg::xlen_t regs [32];

	// x0 never written, stays at its reset value
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (rd_wen && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] xlen_t;

	localparam logic [6:0] OP_LUI   = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL   = 7'b1101111;
	localparam logic [6:0] OP_JALR  = 7'b1100111;
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_IMM   = 7'b0010011;
	localparam logic [6:0] OP_REG   = 7'b0110011;
	localparam logic [6:0] OP_STORE = 7'b0100011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi; // imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // imm[4:0]
		logic [6:0] opcode;
	} s_fmt_t;

	// branch layout, no branch unit behind it
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm20; // imm[31:12]
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_t;

endpackage

// ==== tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk; // 50% duty
		end
	end

endmodule

// ==== tb_cpu.sv ====
module tb_cpu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam rv_pkg::xlen_t RESET_PC = 32'h0000_0040;
	localparam int NUM_CYCLES = 600;

	logic          clk;
	logic          rst = 1'b1;
	rv_pkg::xlen_t imem_data;
	rv_pkg::xlen_t dmem_rdata;
	rv_pkg::xlen_t imem_addr;
	rv_pkg::xlen_t dmem_addr;
	rv_pkg::xlen_t dmem_wdata;
	logic [7:0]    dmem_wmask;
	logic          dmem_wen;
	logic          dmem_ren;

	rv_pkg::xlen_t  imem [256];
	rv_pkg::xlen_t  dmem [64];
	rv_pkg::xlen_t  m_dmem [64]; // reference copy of data memory
	rv_pkg::xlen_t  m_regs [32];
	rv_pkg::xlen_t  m_pc;
	rv_pkg::instr_t m_ir;
	rv_pkg::instr_t cur_ir;
	rv_pkg::xlen_t  m_st_addr;
	rv_pkg::xlen_t  m_st_data;
	rv_pkg::xlen_t  byte_en;
	logic [7:0]     m_st_mask;
	logic           m_st;
	logic           m_ren;
	logic [4:0]     cur_rs2;
	logic [15:0]    lfsr = 16'd79;
	int             errors = 0;
	int             stores = 0;

	tb_clock #(.PERIOD(40)) u_clock (.clk(clk));

	cpu_top #(
		.RESET_PC(RESET_PC)
	) uut (
		.clk        (clk),
		.rst        (rst),
		.imem_data  (imem_data),
		.dmem_rdata (dmem_rdata),
		.imem_addr  (imem_addr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wmask (dmem_wmask),
		.dmem_wen   (dmem_wen),
		.dmem_ren   (dmem_ren)
	);

	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[7:2]];
	assign cur_ir     = imem_data;
	assign cur_rs2    = cur_ir.s.rs2;
	assign byte_en    = {{8{dmem_wmask[3]}}, {8{dmem_wmask[2]}},
		{8{dmem_wmask[1]}}, {8{dmem_wmask[0]}}};

	always @(posedge clk) begin
		if (dmem_wen) begin
			dmem[dmem_addr[7:2]] <= (dmem[dmem_addr[7:2]] & ~byte_en) | (dmem_wdata & byte_en);
		end
	end

	// expected store strobes for the instruction at the model pc
	assign m_ir      = imem[m_pc[9:2]];
	assign m_st      = (m_ir.s.opcode == rv_pkg::OP_STORE) && (m_ir.s.funct3 < 3'd3);
	assign m_st_addr = m_regs[m_ir.s.rs1] + {{20{m_ir.s.imm_hi[6]}}, m_ir.s.imm_hi, m_ir.s.imm_lo};
	assign m_st_data = m_regs[m_ir.s.rs2];
	assign m_st_mask = (m_ir.s.funct3 == 3'd0) ? 8'h1 : (m_ir.s.funct3 == 3'd1) ? 8'h3 : 8'hf;
	assign m_ren     = (m_ir.r.opcode == rv_pkg::OP_LOAD) || (m_ir.r.opcode == rv_pkg::OP_STORE);

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
	endfunction

	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic rv_pkg::xlen_t make_instr();
		rv_pkg::instr_t ir;
		logic [3:0] kind;
		kind = 4'(lfsr_bits(4));
		ir = lfsr_bits(32);
		ir.r.rd  = 5'(lfsr_bits(3)); // x0..x7 only
		ir.r.rs1 = 5'(lfsr_bits(3));
		ir.r.rs2 = 5'(lfsr_bits(3));
		case (kind)
			4'd0: ir.u.opcode = rv_pkg::OP_LUI;
			4'd1: ir.u.opcode = rv_pkg::OP_AUIPC;
			4'd2: begin
				ir.j = '{1'b0, {5'b0, 3'(lfsr_bits(3)), 2'b10}, 1'b0, 8'h0, ir.j.rd, rv_pkg::OP_JAL};
			end
			4'd3: begin
				ir.i.opcode = rv_pkg::OP_JALR;
				ir.i.funct3 = 3'd0;
			end
			4'd4, 4'd5: begin
				ir.i = '{{4'b0, 6'(lfsr_bits(6)), 2'b0}, 5'd0, 3'd2, ir.i.rd, rv_pkg::OP_LOAD};
			end
			4'd6, 4'd7: begin
				ir.i.opcode = rv_pkg::OP_IMM;
				ir.i.funct3 = 3'd0;
			end
			4'd8, 4'd9: begin
				ir.r.opcode = rv_pkg::OP_REG;
				ir.r.funct3 = 3'd0;
				ir.r.funct7 = 7'd0;
			end
			4'd10, 4'd11, 4'd12, 4'd13: begin
				ir.s.opcode = rv_pkg::OP_STORE;
				ir.s.funct3 = (kind < 4'd12) ? 3'(kind - 4'd10) : 3'd2;
				ir.s.rs1    = 5'd0; // small absolute address
				ir.s.imm_hi = {4'b0, 3'(lfsr_bits(3))};
				ir.s.imm_lo = {3'(lfsr_bits(3)), 2'b0};
			end
			default: ir.r.opcode = kind[0] ? 7'b1110011 : 7'b1100011; // system, branch
		endcase
		return ir;
	endfunction

	task automatic write_reg(input logic [4:0] rd, input rv_pkg::xlen_t v);
		if (rd != 5'd0) begin
			m_regs[rd] <= v;
		end
	endtask

	task automatic step_model();
		rv_pkg::instr_t ir;
		rv_pkg::xlen_t a;
		rv_pkg::xlen_t b;
		rv_pkg::xlen_t imm_i;
		rv_pkg::xlen_t nxt;
		rv_pkg::xlen_t word;
		logic [5:0] wi;
		ir = imem[m_pc[9:2]];
		a = m_regs[ir.r.rs1];
		b = m_regs[ir.r.rs2];
		imm_i = {{20{ir.i.imm12[11]}}, ir.i.imm12};
		nxt = m_pc + 32'd4;
		case (ir.r.opcode)
			rv_pkg::OP_LUI: write_reg(ir.r.rd, {ir.u.imm20, 12'b0});
			rv_pkg::OP_AUIPC: write_reg(ir.r.rd, m_pc + {ir.u.imm20, 12'b0});
			rv_pkg::OP_JAL: begin
				write_reg(ir.r.rd, m_pc + 32'd4);
				nxt = m_pc + {{12{ir.j.imm20}}, ir.j.imm19_12, ir.j.imm11, ir.j.imm10_1, 1'b0};
			end
			rv_pkg::OP_JALR: begin
				write_reg(ir.r.rd, m_pc + 32'd4);
				nxt = (a + imm_i) & ~32'd1;
			end
			rv_pkg::OP_LOAD: begin
				word = a + imm_i;
				write_reg(ir.r.rd, m_dmem[word[7:2]]);
			end
			rv_pkg::OP_IMM: write_reg(ir.r.rd, a + imm_i);
			rv_pkg::OP_REG: write_reg(ir.r.rd, a + b);
			rv_pkg::OP_STORE: begin
				word = a + {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
				wi = word[7:2];
				word = m_dmem[wi];
				case (ir.s.funct3)
					3'd0: word[7:0] = b[7:0];
					3'd1: word[15:0] = b[15:0];
					default: word = b;
				endcase
				m_dmem[wi] <= word;
				stores++;
			end
			default: begin
			end
		endcase
		m_pc <= nxt;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			m_pc <= RESET_PC;
			for (int k = 0; k < 32; k++) begin
				m_regs[5'(k)] <= '0;
			end
		end else begin
			step_model();
		end
	end

	task automatic report_mismatch(input string name, input rv_pkg::xlen_t got,
		input rv_pkg::xlen_t exp);
		errors++;
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
	endtask

	a_pc: assert property (@(posedge clk) !rst |-> imem_addr == m_pc)
		else report_mismatch("imem_addr", $sampled(imem_addr), $sampled(m_pc));
	a_rst_pc: assert property (@(posedge clk) $fell(rst) |-> imem_addr == RESET_PC)
		else report_mismatch("imem_addr", $sampled(imem_addr), RESET_PC);
	a_rst_wen: assert property (@(posedge clk) rst |-> !dmem_wen)
		else report_mismatch("dmem_wen", 32'($sampled(dmem_wen)), 32'd0);
	a_wen: assert property (@(posedge clk) !rst |-> dmem_wen == m_st)
		else report_mismatch("dmem_wen", 32'($sampled(dmem_wen)), 32'($sampled(m_st)));
	a_ren: assert property (@(posedge clk) !rst |-> dmem_ren == m_ren)
		else report_mismatch("dmem_ren", 32'($sampled(dmem_ren)), 32'($sampled(m_ren)));
	a_addr: assert property (@(posedge clk) (!rst && m_st) |-> dmem_addr == m_st_addr)
		else report_mismatch("dmem_addr", $sampled(dmem_addr), $sampled(m_st_addr));
	a_wdata: assert property (@(posedge clk) (!rst && m_st) |-> dmem_wdata == m_st_data)
		else report_mismatch("dmem_wdata", $sampled(dmem_wdata), $sampled(m_st_data));
	a_mask: assert property (@(posedge clk) (!rst && m_st) |-> dmem_wmask == m_st_mask)
		else report_mismatch("dmem_wmask", 32'($sampled(dmem_wmask)), 32'($sampled(m_st_mask)));
	a_x0: assert property (@(posedge clk) (dmem_wen && cur_rs2 == 5'd0) |-> dmem_wdata == 32'd0)
		else report_mismatch("dmem_wdata", $sampled(dmem_wdata), 32'd0);

	initial begin
		for (int k = 0; k < 256; k++) begin
			imem[8'(k)] = make_instr();
		end
		imem[RESET_PC[9:2]] = {7'd0, 5'd0, 5'd0, 3'd2, 5'd0, rv_pkg::OP_STORE}; // sw held in reset
		for (int k = 0; k < 64; k++) begin
			dmem[6'(k)] <= {8'hd0, 8'(k), 8'(~k), 8'(k * 37)};
			m_dmem[6'(k)] <= {8'hd0, 8'(k), 8'(~k), 8'(k * 37)};
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		imem[RESET_PC[9:2]] = {20'h12345, 5'd1, rv_pkg::OP_LUI}; // no store right after reset
		@(posedge clk);
		rst <= 1'b0;
		repeat (NUM_CYCLES) @(posedge clk);
		@(negedge clk);
		if (stores == 0) begin
			errors++;
			$display("no store instruction was executed");
		end
		$display("errors: %0d, stores: %0d, cycles: %0d", errors, stores, NUM_CYCLES);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#((NUM_CYCLES + 10) * 40);
		$display("timeout: the run did not finish in the expected time");
		$display("test failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
rv_pkg.sv
pc_reg.sv
idu.sv
regfile.sv
exu.sv
cpu_top.sv
tb_clock.sv
tb_cpu.sv
